/* mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// word width in bits.
`define WORD_SIZE 16

// words per block.
`define BLOCK_SIZE 8

// low pointer bits that pick a word inside a block.
`define BLOCK_INDEX 3

// memory depth in words, and the pointer width that spans it.
`define MEM_SIZE 256
`define PTR_W 8

`endif

/* mem_pkg.sv */
`include "mem_consts.svh"

package mem_pkg;

    typedef logic [`WORD_SIZE-1:0] word_t;

    // ascending packed range, so word 0 sits in the most significant slot.
    typedef word_t [0:`BLOCK_SIZE-1] block_t;

    typedef logic [`PTR_W-1:0] ptr_t;

endpackage

/* cmd_pkg.sv */
package cmd_pkg;

    // codes 5 to 7 are illegal.
    typedef enum logic [2:0] {
        OP_READ_WORD   = 3'd0,
        OP_WRITE_WORD  = 3'd1,
        OP_READ_BLOCK  = 3'd2,
        OP_WRITE_BLOCK = 3'd3,
        OP_COPY_BLOCK  = 3'd4
    } op_e;

    typedef enum logic {
        ST_OK     = 1'b0,
        ST_BAD_OP = 1'b1
    } status_e;

    typedef enum logic [1:0] {
        WR_NONE  = 2'd0,
        WR_MERGE = 2'd1,
        WR_BLOCK = 2'd2,
        WR_COPY  = 2'd3
    } wr_kind_e;

    typedef struct packed {
        op_e             op;
        mem_pkg::ptr_t   addr;
        mem_pkg::ptr_t   src;
        mem_pkg::word_t  wdata;
        mem_pkg::block_t wblock;
    } cmd_t;

    typedef struct packed {
        op_e             op;
        status_e         status;
        mem_pkg::ptr_t   rd_ptr;
        mem_pkg::ptr_t   wr_ptr;
        wr_kind_e        wr_kind;
        mem_pkg::word_t  wdata;
        mem_pkg::block_t wblock;
    } dec_t;

    typedef struct packed {
        op_e             op;
        status_e         status;
        mem_pkg::word_t  word;
        mem_pkg::block_t block;
    } resp_t;

endpackage

/* data_memory.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module data_memory (
    input  logic            clk,
    input  mem_pkg::ptr_t   ptr_in,
    input  mem_pkg::block_t in_block,
    input  logic            write_enable,
    input  mem_pkg::ptr_t   ptr_out,
    output mem_pkg::word_t  out_data,
    output mem_pkg::block_t out_block
);

    mem_pkg::word_t mem [0:`MEM_SIZE-1];

    mem_pkg::ptr_t rd_base;
    mem_pkg::ptr_t wr_base;

    // both ports work on whole aligned blocks.
    assign rd_base = {ptr_out[`PTR_W-1:`BLOCK_INDEX], {`BLOCK_INDEX{1'b0}}};
    assign wr_base = {ptr_in[`PTR_W-1:`BLOCK_INDEX], {`BLOCK_INDEX{1'b0}}};

    initial begin
        for (int i = 0; i < `MEM_SIZE; i++) begin
            mem[i] = '0;
        end
    end

    assign out_data = mem[ptr_out];

    for (genvar g = 0; g < `BLOCK_SIZE; g++) begin : g_rd
        assign out_block[g] = mem[rd_base + mem_pkg::ptr_t'(g)];
    end

    always_ff @(posedge clk) begin
        if (write_enable) begin
            for (int i = 0; i < `BLOCK_SIZE; i++) begin
                mem[wr_base + mem_pkg::ptr_t'(i)] <= in_block[i];
            end
        end
    end

    // an unknown enable would corrupt a whole block silently.
    a_we_known: assert property (@(posedge clk) !$isunknown(write_enable))
        else $error("data_memory: write_enable is unknown");

endmodule

/* cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cmd_valid,
    input  cmd_pkg::cmd_t cmd,
    output logic          dec_valid,
    output cmd_pkg::dec_t dec
);

    cmd_pkg::dec_t dec_nxt;

    always_comb begin
        dec_nxt.op      = cmd.op;
        dec_nxt.status  = cmd_pkg::ST_OK;
        dec_nxt.rd_ptr  = cmd.addr;
        dec_nxt.wr_ptr  = cmd.addr;
        dec_nxt.wr_kind = cmd_pkg::WR_NONE;
        dec_nxt.wdata   = cmd.wdata;
        dec_nxt.wblock  = cmd.wblock;
        case (cmd.op)
            cmd_pkg::OP_READ_WORD: begin
                dec_nxt.wr_kind = cmd_pkg::WR_NONE;
            end
            cmd_pkg::OP_WRITE_WORD: begin
                // read the target block so one word can be merged into it.
                dec_nxt.wr_kind = cmd_pkg::WR_MERGE;
            end
            cmd_pkg::OP_READ_BLOCK: begin
                dec_nxt.wr_kind = cmd_pkg::WR_NONE;
            end
            cmd_pkg::OP_WRITE_BLOCK: begin
                dec_nxt.wr_kind = cmd_pkg::WR_BLOCK;
            end
            cmd_pkg::OP_COPY_BLOCK: begin
                dec_nxt.rd_ptr  = cmd.src;
                dec_nxt.wr_kind = cmd_pkg::WR_COPY;
            end
            default: begin
                dec_nxt.status  = cmd_pkg::ST_BAD_OP;
                dec_nxt.wr_kind = cmd_pkg::WR_NONE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= cmd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            dec <= dec_nxt;
        end
    end

    // a rejected opcode must never reach the memory write port.
    a_bad_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && dec.status == cmd_pkg::ST_BAD_OP |-> dec.wr_kind == cmd_pkg::WR_NONE)
        else $error("cmd_decode: illegal opcode decoded with a write");

endmodule

/* mem_stage.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           dec_valid,
    input  cmd_pkg::dec_t  dec,
    output logic           resp_valid,
    output cmd_pkg::resp_t resp
);

    mem_pkg::word_t  rd_word;
    mem_pkg::block_t rd_block;
    mem_pkg::block_t wr_block;
    logic            write_enable;
    logic            ok;

    data_memory mem_i (
        .clk          (clk),
        .ptr_in       (dec.wr_ptr),
        .in_block     (wr_block),
        .write_enable (write_enable),
        .ptr_out      (dec.rd_ptr),
        .out_data     (rd_word),
        .out_block    (rd_block)
    );

    always_comb begin
        wr_block = rd_block;
        case (dec.wr_kind)
            cmd_pkg::WR_MERGE: begin
                // for a merge rd_ptr and wr_ptr are the same block.
                wr_block[dec.wr_ptr[`BLOCK_INDEX-1:0]] = dec.wdata;
            end
            cmd_pkg::WR_BLOCK: begin
                wr_block = dec.wblock;
            end
            cmd_pkg::WR_COPY: begin
                wr_block = rd_block;
            end
            default: begin
                wr_block = rd_block;
            end
        endcase
    end

    assign write_enable = dec_valid && (dec.wr_kind != cmd_pkg::WR_NONE);
    assign ok           = (dec.status == cmd_pkg::ST_OK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= dec_valid;
        end
    end

    // the response carries the memory contents from before this write.
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            resp.op     <= dec.op;
            resp.status <= dec.status;
            resp.word   <= ok ? rd_word : '0;
            resp.block  <= ok ? rd_block : '0;
        end
    end

    // every write belongs to a live command that passed decode.
    a_we_valid: assert property (@(posedge clk) disable iff (!rst_n)
        write_enable |-> dec_valid && dec.status == cmd_pkg::ST_OK)
        else $error("mem_stage: write for an idle or rejected command");

endmodule

/* block_mover.sv */
`timescale 1ns/1ps

module block_mover (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cmd_valid,
    input  cmd_pkg::cmd_t  cmd,
    output logic           resp_valid,
    output cmd_pkg::resp_t resp
);

    logic          dec_valid;
    cmd_pkg::dec_t dec;

    cmd_decode decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    mem_stage stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

/* tb_block_mover.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_block_mover;

    localparam int RAND_CMDS       = 400;
    localparam int DIRECTED_CYCLES = 60;
    localparam int RESET_CYCLES    = 3;
    localparam int MARGIN_NS       = 200;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           cmd_valid;
    cmd_pkg::cmd_t  cmd;
    logic           resp_valid;
    cmd_pkg::resp_t resp;

    mem_pkg::word_t model_mem [0:`MEM_SIZE-1];
    logic           pend_v [$];
    cmd_pkg::resp_t pend_r [$];
    int             checks;
    int             errors;
    int             err_mark;

    block_mover dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    always #2 clk = ~clk;

    // one clock period per command or idle cycle, plus reset and a margin.
    initial begin
        #((RAND_CMDS + DIRECTED_CYCLES + RESET_CYCLES) * 4 + MARGIN_NS);
        $display("timeout: the run did not finish in the expected time");
        $display("TEST FAIL");
        $finish;
    end

    function automatic mem_pkg::block_t rand_block();
        mem_pkg::block_t b;
        for (int i = 0; i < `BLOCK_SIZE; i++) begin
            b[i] = mem_pkg::word_t'($urandom);
        end
        return b;
    endfunction

    // reference model; the response shows memory as it was before the write.
    function automatic cmd_pkg::resp_t model_cmd(input cmd_pkg::cmd_t c);
        cmd_pkg::resp_t r;
        mem_pkg::ptr_t  rd;
        mem_pkg::ptr_t  rd_base;
        mem_pkg::ptr_t  wr_base;
        r      = '0;
        r.op   = c.op;
        rd     = (c.op == cmd_pkg::OP_COPY_BLOCK) ? c.src : c.addr;
        rd_base = rd & ~mem_pkg::ptr_t'(`BLOCK_SIZE - 1);
        wr_base = c.addr & ~mem_pkg::ptr_t'(`BLOCK_SIZE - 1);
        if (c.op > cmd_pkg::OP_COPY_BLOCK) begin
            r.status = cmd_pkg::ST_BAD_OP;
            return r;
        end
        r.status = cmd_pkg::ST_OK;
        r.word   = model_mem[rd];
        for (int i = 0; i < `BLOCK_SIZE; i++) begin
            r.block[i] = model_mem[rd_base + mem_pkg::ptr_t'(i)];
        end
        case (c.op)
            cmd_pkg::OP_WRITE_WORD: begin
                model_mem[c.addr] = c.wdata;
            end
            cmd_pkg::OP_WRITE_BLOCK: begin
                for (int i = 0; i < `BLOCK_SIZE; i++) begin
                    model_mem[wr_base + mem_pkg::ptr_t'(i)] = c.wblock[i];
                end
            end
            cmd_pkg::OP_COPY_BLOCK: begin
                for (int i = 0; i < `BLOCK_SIZE; i++) begin
                    model_mem[wr_base + mem_pkg::ptr_t'(i)] = r.block[i];
                end
            end
            default: begin
            end
        endcase
        return r;
    endfunction

    task automatic check_valid(input logic expected);
        checks++;
        if (resp_valid !== expected) begin
            errors++;
            if (expected) begin
                $display("missing response at %0t ns: resp_valid stayed low", $time);
            end else begin
                $display("unexpected response at %0t ns: resp_valid rose with no command",
                         $time);
            end
        end
    endtask

    task automatic compare_resp(input cmd_pkg::resp_t got, input cmd_pkg::resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: op %0d got status %0d word %h block %h",
                     $time, exp.op, got.status, got.word, got.block);
            $display("   expected status %0d word %h block %h",
                     exp.status, exp.word, exp.block);
        end
    endtask

    // check the response due this cycle, then drive the next input.
    task automatic step(input logic v, input cmd_pkg::cmd_t c);
        logic           exp_v;
        cmd_pkg::resp_t exp;
        @(negedge clk);
        exp_v = pend_v.pop_front();
        exp   = pend_r.pop_front();
        check_valid(exp_v);
        if (exp_v && resp_valid) begin
            compare_resp(resp, exp);
        end
        cmd_valid = v;
        cmd       = c;
        if (v) begin
            exp = model_cmd(c);
        end else begin
            exp = '0;
        end
        pend_v.push_back(v);
        pend_r.push_back(exp);
    endtask

    task automatic issue(input cmd_pkg::op_e op, input mem_pkg::ptr_t addr,
                         input mem_pkg::ptr_t src, input mem_pkg::word_t wdata,
                         input mem_pkg::block_t wblock);
        cmd_pkg::cmd_t c;
        c.op     = op;
        c.addr   = addr;
        c.src    = src;
        c.wdata  = wdata;
        c.wblock = wblock;
        step(1'b1, c);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            step(1'b0, '0);
        end
    endtask

    task automatic end_test(input int num, input string name);
        idle(2);
        if (errors == err_mark) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        cmd_pkg::cmd_t   c;
        mem_pkg::block_t blk;
        void'($urandom(91));
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        checks    = 0;
        errors    = 0;
        err_mark  = 0;
        for (int i = 0; i < `MEM_SIZE; i++) begin
            model_mem[i] = '0;
        end
        repeat (2) begin
            pend_v.push_back(1'b0);
            pend_r.push_back('0);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        idle(4);
        issue(cmd_pkg::OP_READ_BLOCK, mem_pkg::ptr_t'($urandom), '0, '0, '0);
        issue(cmd_pkg::OP_READ_WORD, mem_pkg::ptr_t'($urandom), '0, '0, '0);
        end_test(1, "idle after reset and zero memory");

        blk = rand_block();
        issue(cmd_pkg::OP_WRITE_BLOCK, 8'h10, '0, '0, blk);
        for (int i = 0; i < `BLOCK_SIZE; i++) begin
            issue(cmd_pkg::OP_READ_WORD, 8'h10 + mem_pkg::ptr_t'(i), '0, '0, '0);
        end
        // an unaligned address still writes the whole enclosing block.
        blk = rand_block();
        issue(cmd_pkg::OP_WRITE_BLOCK, 8'h2d, '0, '0, blk);
        for (int i = 0; i < `BLOCK_SIZE; i++) begin
            issue(cmd_pkg::OP_READ_WORD, 8'h28 + mem_pkg::ptr_t'(i), '0, '0, '0);
        end
        end_test(2, "block write then word reads");

        blk = rand_block();
        issue(cmd_pkg::OP_WRITE_BLOCK, 8'h30, '0, '0, blk);
        issue(cmd_pkg::OP_WRITE_WORD, 8'h33, '0, 16'hbeef, '0);
        issue(cmd_pkg::OP_WRITE_WORD, 8'h36, '0, 16'h1234, '0);
        issue(cmd_pkg::OP_READ_BLOCK, 8'h30, '0, '0, '0);
        end_test(3, "word merge");

        blk = rand_block();
        issue(cmd_pkg::OP_WRITE_BLOCK, 8'h40, '0, '0, blk);
        issue(cmd_pkg::OP_COPY_BLOCK, 8'h83, 8'h45, '0, '0);
        issue(cmd_pkg::OP_READ_BLOCK, 8'h80, '0, '0, '0);
        issue(cmd_pkg::OP_READ_BLOCK, 8'h40, '0, '0, '0);
        end_test(4, "block copy");

        blk = rand_block();
        issue(cmd_pkg::OP_WRITE_BLOCK, 8'h60, '0, '0, blk);
        for (int k = 5; k < 8; k++) begin
            issue(cmd_pkg::op_e'(3'(k)), 8'h60, 8'h40, 16'hffff, rand_block());
        end
        issue(cmd_pkg::OP_READ_BLOCK, 8'h60, '0, '0, '0);
        end_test(5, "illegal opcodes");

        // a small address range keeps the commands hitting the same blocks.
        for (int n = 0; n < RAND_CMDS; n++) begin
            c.op     = cmd_pkg::op_e'(3'($urandom_range(0, 7)));
            c.addr   = mem_pkg::ptr_t'($urandom_range(0, 31));
            c.src    = mem_pkg::ptr_t'($urandom_range(0, 31));
            c.wdata  = mem_pkg::word_t'($urandom);
            c.wblock = rand_block();
            step(1'b1, c);
        end
        end_test(6, "random back-to-back commands");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* block_mover.f */
+incdir+.
mem_pkg.sv
cmd_pkg.sv
data_memory.sv
cmd_decode.sv
mem_stage.sv
block_mover.sv
tb_block_mover.sv

/* run.sh */
#!/bin/sh
# Compile the testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f block_mover.f \
    --top-module tb_block_mover \
    -o sim_block_mover

out=$(./obj_dir/sim_block_mover)
echo "$out"

# The result is decided by the pass line alone.
echo "$out" | grep -qx "TEST PASS"
